// File: common/ppu_pkg.sv
// --------------------------------------------------
// lcd controller shared package
// timing constants, register map and common types
// --------------------------------------------------

package ppu_pkg;

	// width types
	typedef logic [8:0] hpos_t;
	typedef logic [7:0] line_t;
	typedef logic [7:0] byte_t;

	// stat mode bits as seen by the cpu
	typedef enum logic [1:0] {
		MODE_HBLANK = 2'd0,
		MODE_VBLANK = 2'd1,
		MODE_OAM    = 2'd2,
		MODE_XFER   = 2'd3
	} lcd_mode_e;

	// register addresses, low byte of 0xff4x
	typedef enum logic [7:0] {
		REG_LCDC = 8'h40,
		REG_STAT = 8'h41,
		REG_SCX  = 8'h43,
		REG_LY   = 8'h44,
		REG_LYC  = 8'h45,
		REG_DMA  = 8'h46
	} reg_addr_e;

	// --------------------------------------------------
	// line and frame timing
	localparam hpos_t LINE_CYCLES    = 9'd456;
	localparam line_t FRAME_LINES    = 8'd154;
	localparam line_t VISIBLE_LINES  = 8'd144;
	localparam hpos_t OAM_CYCLES     = 9'd80;
	localparam hpos_t VISIBLE_PIXELS = 9'd160;
	localparam hpos_t MODE3_OFFSET   = 9'd16;
	// scx sampled two clocks before mode 3 starts
	localparam hpos_t SCROLL_LATCH_H = 9'd78;
	// h count parks here while the lcd is off
	localparam hpos_t LCD_OFF_H      = 9'd6;

	// --------------------------------------------------
	// oam and dma
	localparam int DMA_BYTES  = 160;
	localparam int DMA_CYCLES = 4;
	localparam int OAM_BYTES  = 160;

endpackage

// File: rtl/line_timer.sv
// --------------------------------------------------
// line timer
// h/v counters, stat mode decode and the
// one-cycle line event strobes
// --------------------------------------------------

module line_timer (
	input  logic              clk_reg,
	input  logic              reset,
	input  logic              lcd_on,
	input  ppu_pkg::byte_t    scx,
	output ppu_pkg::hpos_t    h_pos,
	output ppu_pkg::line_t    ly,
	output ppu_pkg::lcd_mode_e mode,
	output logic              line_start,
	output logic              hblank_start,
	output logic              vblank_start
);

	// fine scroll bits, held stable over the line
	logic [2:0]     scx_fine;
	ppu_pkg::hpos_t hblank_pos;
	logic           vblank;
	logic           line_end;

	assign vblank   = (ly >= ppu_pkg::VISIBLE_LINES);
	assign line_end = (h_pos == ppu_pkg::LINE_CYCLES - 9'd1);

	// unaligned scx costs one extra 8 pixel fetch in mode 3
	assign hblank_pos = ppu_pkg::OAM_CYCLES + ppu_pkg::VISIBLE_PIXELS + ppu_pkg::MODE3_OFFSET
		+ ((scx_fine != 3'd0) ? 9'd8 : 9'd0);

	// --------------------------------------------------
	// counters
	always_ff @(posedge clk_reg) begin
		if (reset || !lcd_on) begin
			// lcd off restarts the line a few clocks in
			h_pos <= ppu_pkg::LCD_OFF_H;
			ly    <= 8'd0;
		end else if (line_end) begin
			h_pos <= 9'd0;
			// wrap to line 0 after the last vblank line
			if (ly == ppu_pkg::FRAME_LINES - 8'd1)
				ly <= 8'd0;
			else
				ly <= ly + 8'd1;
		end else begin
			h_pos <= h_pos + 9'd1;
		end
	end

	always_ff @(posedge clk_reg) begin
		if (reset)
			scx_fine <= 3'd0;
		else if (h_pos == ppu_pkg::SCROLL_LATCH_H)
			scx_fine <= scx[2:0];
	end

	// mode decode, lcd off always reports hblank
	always_comb begin
		if (!lcd_on)
			mode = ppu_pkg::MODE_HBLANK;
		else if (vblank)
			mode = ppu_pkg::MODE_VBLANK;
		else if (h_pos < ppu_pkg::OAM_CYCLES)
			mode = ppu_pkg::MODE_OAM;
		else if (h_pos < hblank_pos)
			mode = ppu_pkg::MODE_XFER;
		else
			mode = ppu_pkg::MODE_HBLANK;
	end

	// event strobes
	assign line_start   = lcd_on && !vblank && (h_pos == 9'd0);
	assign hblank_start = lcd_on && !vblank && (h_pos == hblank_pos);
	// last clock of the last visible line
	assign vblank_start = lcd_on && line_end && (ly == ppu_pkg::VISIBLE_LINES - 8'd1);

endmodule

// File: rtl/lcd_regs.sv
// --------------------------------------------------
// lcd register file
// lcdc, stat, scx, ly, lyc and dma at 0xff40..0xff46
// plus the cpu read mux
// --------------------------------------------------

module lcd_regs (
	input  logic               clk_reg,
	input  logic               reset,
	input  logic               cpu_sel_reg,
	input  logic               cpu_sel_oam,
	input  logic               cpu_wr,
	input  ppu_pkg::byte_t     cpu_addr,
	input  ppu_pkg::byte_t     cpu_di,
	input  ppu_pkg::line_t     ly,
	input  ppu_pkg::lcd_mode_e mode,
	input  ppu_pkg::byte_t     oam_rdata,
	output ppu_pkg::byte_t     cpu_do,
	output logic               lcd_on,
	output logic               lyc_match,
	output logic               lyc_write,
	output logic               dma_start,
	output logic [3:0]         stat_en,
	output ppu_pkg::byte_t     scx,
	output ppu_pkg::byte_t     dma_page
);

	ppu_pkg::byte_t lcdc;
	ppu_pkg::byte_t lyc;
	logic           reg_wr;

	assign reg_wr = cpu_sel_reg && cpu_wr;

	// lcdc bit 7 is the only lcdc bit that drives control logic
	assign lcd_on    = lcdc[7];
	assign lyc_match = (ly == lyc);

	// write strobes used by other blocks
	assign lyc_write = reg_wr && (cpu_addr == ppu_pkg::REG_LYC);
	assign dma_start = reg_wr && (cpu_addr == ppu_pkg::REG_DMA);

	// --------------------------------------------------
	// register writes
	always_ff @(posedge clk_reg) begin
		if (reset) begin
			lcdc     <= 8'h00;
			stat_en  <= 4'h0;
			scx      <= 8'h00;
			lyc      <= 8'h00;
			dma_page <= 8'h00;
		end else if (reg_wr) begin
			// ly is read only and drops writes
			case (cpu_addr)
				ppu_pkg::REG_LCDC:
					lcdc <= cpu_di;
				ppu_pkg::REG_STAT:
					stat_en <= cpu_di[6:3];
				ppu_pkg::REG_SCX:
					scx <= cpu_di;
				ppu_pkg::REG_LYC:
					lyc <= cpu_di;
				ppu_pkg::REG_DMA:
					dma_page <= cpu_di;
				default: ;
			endcase
		end
	end

	// --------------------------------------------------
	// read mux is combinational in the access cycle
	always_comb begin
		if (cpu_sel_oam) begin
			cpu_do = oam_rdata;
		end else begin
			case (cpu_addr)
				ppu_pkg::REG_LCDC:
					cpu_do = lcdc;
				// bit 7 has no storage and reads as one
				ppu_pkg::REG_STAT:
					cpu_do = {1'b1, stat_en, lyc_match, mode};
				ppu_pkg::REG_SCX:
					cpu_do = scx;
				ppu_pkg::REG_LY:
					cpu_do = ly;
				ppu_pkg::REG_LYC:
					cpu_do = lyc;
				ppu_pkg::REG_DMA:
					cpu_do = dma_page;
				// unmapped addresses including 0x42
				default:
					cpu_do = 8'hFF;
			endcase
		end
	end

endmodule

// File: rtl/stat_irq.sv
// --------------------------------------------------
// stat interrupt logic
// merges enabled line events into the lcd irq pulse
// and raises the vblank irq
// --------------------------------------------------

module stat_irq (
	input  logic       clk_reg,
	input  logic       reset,
	input  logic       line_start,
	input  logic       hblank_start,
	input  logic       vblank_start,
	input  logic       lyc_match,
	input  logic       lyc_write,
	input  logic [3:0] stat_en,
	output logic       irq,
	output logic       vblank_irq
);

	// lyc write seen last cycle, compare uses the new lyc
	logic lyc_write_q;
	logic lyc_event;
	logic irq_next;

	// stat_en[3] is stat bit 6, down to stat_en[0] as bit 3
	assign lyc_event = stat_en[3] && lyc_match && (line_start || lyc_write_q);

	assign irq_next = lyc_event
		|| (stat_en[2] && line_start)
		|| (stat_en[1] && vblank_start)
		|| (stat_en[0] && hblank_start);

	always_ff @(posedge clk_reg) begin
		if (reset) begin
			lyc_write_q <= 1'b0;
			irq         <= 1'b0;
			vblank_irq  <= 1'b0;
		end else begin
			lyc_write_q <= lyc_write;
			// single clock pulses, one cycle after the event
			irq         <= irq_next;
			vblank_irq  <= vblank_start;
		end
	end

endmodule

// File: oam_store/oam_store.sv
// --------------------------------------------------
// oam store
// 160 byte sprite attribute memory, cpu port and
// the oam dma copy engine
// --------------------------------------------------

module oam_store (
	input  logic               clk_reg,
	input  logic               reset,
	input  logic               cpu_sel_oam,
	input  logic               cpu_wr,
	input  ppu_pkg::byte_t     cpu_addr,
	input  ppu_pkg::byte_t     cpu_di,
	input  ppu_pkg::lcd_mode_e mode,
	input  logic               dma_start,
	input  ppu_pkg::byte_t     dma_page,
	input  ppu_pkg::byte_t     dma_data,
	output ppu_pkg::byte_t     oam_rdata,
	output logic               dma_rd,
	output logic [15:0]        dma_addr
);

	ppu_pkg::byte_t oam_mem [0:ppu_pkg::OAM_BYTES-1];

	logic           dma_active;
	// four clocks per byte, byte index in the upper bits
	logic [9:0]     dma_cnt;
	logic           cpu_wr_ok;
	logic           oam_we;
	ppu_pkg::byte_t oam_wa;
	ppu_pkg::byte_t oam_wd;

	// --------------------------------------------------
	// dma engine
	always_ff @(posedge clk_reg) begin
		if (reset) begin
			dma_active <= 1'b0;
			dma_cnt    <= 10'd0;
		end else if (dma_start) begin
			// a new write restarts the copy from byte 0
			dma_active <= 1'b1;
			dma_cnt    <= 10'd0;
		end else if (dma_active) begin
			if (dma_cnt == 10'(ppu_pkg::DMA_BYTES * ppu_pkg::DMA_CYCLES - 1))
				dma_active <= 1'b0;
			else
				dma_cnt <= dma_cnt + 10'd1;
		end
	end

	assign dma_rd   = dma_active;
	assign dma_addr = {dma_page, dma_cnt[9:2]};

	// --------------------------------------------------
	// write port arbitration
	// cpu locked out during dma and while the lcd scans oam
	assign cpu_wr_ok = cpu_wr && cpu_sel_oam
		&& (mode != ppu_pkg::MODE_OAM) && (mode != ppu_pkg::MODE_XFER);

	// dma byte lands mid slot, data is settled by then
	assign oam_we = dma_active ? (dma_cnt[1:0] == 2'd2) : cpu_wr_ok;
	assign oam_wa = dma_active ? dma_cnt[9:2] : cpu_addr;
	assign oam_wd = dma_active ? dma_data : cpu_di;

	always_ff @(posedge clk_reg) begin
		if (oam_we && (oam_wa < 8'(ppu_pkg::OAM_BYTES)))
			oam_mem[oam_wa] <= oam_wd;
	end

	// cpu read port is never blocked
	assign oam_rdata = (cpu_addr < 8'(ppu_pkg::OAM_BYTES)) ? oam_mem[cpu_addr] : 8'hFF;

endmodule

// File: rtl/ppu_ctrl.sv
// --------------------------------------------------
// lcd controller top
// timer, registers, interrupts and oam store
// --------------------------------------------------

module ppu_ctrl (
	input  logic               clk_reg,
	input  logic               reset,
	input  logic               cpu_sel_oam,
	input  logic               cpu_sel_reg,
	input  logic               cpu_wr,
	input  ppu_pkg::byte_t     cpu_addr,
	input  ppu_pkg::byte_t     cpu_di,
	input  ppu_pkg::byte_t     dma_data,
	output ppu_pkg::byte_t     cpu_do,
	output logic               lcd_on,
	output ppu_pkg::lcd_mode_e mode,
	output logic               irq,
	output logic               vblank_irq,
	output logic               dma_rd,
	output logic [15:0]        dma_addr
);

	// timer events
	ppu_pkg::line_t ly;
	logic           line_start;
	logic           hblank_start;
	logic           vblank_start;

	// register file outputs
	ppu_pkg::byte_t scx;
	ppu_pkg::byte_t dma_page;
	ppu_pkg::byte_t oam_rdata;
	logic [3:0]     stat_en;
	logic           lyc_match;
	logic           lyc_write;
	logic           dma_start;

	// h count has no consumer outside the timer
	line_timer line_timer_i (
		.clk_reg      (clk_reg),
		.reset        (reset),
		.lcd_on       (lcd_on),
		.scx          (scx),
		.h_pos        (),
		.ly           (ly),
		.mode         (mode),
		.line_start   (line_start),
		.hblank_start (hblank_start),
		.vblank_start (vblank_start)
	);

	lcd_regs lcd_regs_i (
		.clk_reg     (clk_reg),
		.reset       (reset),
		.cpu_sel_reg (cpu_sel_reg),
		.cpu_sel_oam (cpu_sel_oam),
		.cpu_wr      (cpu_wr),
		.cpu_addr    (cpu_addr),
		.cpu_di      (cpu_di),
		.ly          (ly),
		.mode        (mode),
		.oam_rdata   (oam_rdata),
		.cpu_do      (cpu_do),
		.lcd_on      (lcd_on),
		.lyc_match   (lyc_match),
		.lyc_write   (lyc_write),
		.dma_start   (dma_start),
		.stat_en     (stat_en),
		.scx         (scx),
		.dma_page    (dma_page)
	);

	stat_irq stat_irq_i (
		.clk_reg      (clk_reg),
		.reset        (reset),
		.line_start   (line_start),
		.hblank_start (hblank_start),
		.vblank_start (vblank_start),
		.lyc_match    (lyc_match),
		.lyc_write    (lyc_write),
		.stat_en      (stat_en),
		.irq          (irq),
		.vblank_irq   (vblank_irq)
	);

	oam_store oam_store_i (
		.clk_reg     (clk_reg),
		.reset       (reset),
		.cpu_sel_oam (cpu_sel_oam),
		.cpu_wr      (cpu_wr),
		.cpu_addr    (cpu_addr),
		.cpu_di      (cpu_di),
		.mode        (mode),
		.dma_start   (dma_start),
		.dma_page    (dma_page),
		.dma_data    (dma_data),
		.oam_rdata   (oam_rdata),
		.dma_rd      (dma_rd),
		.dma_addr    (dma_addr)
	);

endmodule

// File: tests/ppu_checker.sv
// --------------------------------------------------
// lcd controller checker
// compares read data, mode, lcd enable and dma
// activity, and counts irq pulses
// --------------------------------------------------

module ppu_checker (
	input  logic       clk_reg,
	input  logic       reset,
	input  logic [7:0] cpu_addr,
	input  logic [7:0] cpu_do,
	input  logic [1:0] mode,
	input  logic       irq,
	input  logic       vblank_irq,
	input  logic       lcd_on,
	input  logic       dma_rd,
	input  logic       read_chk,
	input  logic [7:0] read_exp,
	input  logic       mode_chk,
	input  logic [1:0] mode_exp,
	input  logic       lcd_exp,
	input  logic       dma_exp,
	input  logic       win_on,
	input  logic       win_close,
	input  int         exp_irq,
	input  int         exp_vblank,
	output int         read_errors,
	output int         mode_errors,
	output int         count_errors,
	output int         status_errors
);
	timeunit 1ns;
	timeprecision 100ps;

	// pulse counts of the open window
	int irq_cnt;
	int vblank_cnt;
	int irq_total;
	int vblank_total;

	// sample on the falling edge where inputs and outputs have settled
	always @(negedge clk_reg) begin
		if (reset) begin
			read_errors   = 0;
			mode_errors   = 0;
			count_errors  = 0;
			status_errors = 0;
			irq_cnt       = 0;
			vblank_cnt    = 0;
		end else begin
			if (read_chk && (cpu_do !== read_exp)) begin
				$display("error at %0d ns: read of %02h returned %02h, expected %02h",
					$time, cpu_addr, cpu_do, read_exp);
				read_errors = read_errors + 1;
			end
			if (mode_chk && (mode !== mode_exp)) begin
				$display("error at %0d ns: mode %0d, expected %0d", $time, mode, mode_exp);
				mode_errors = mode_errors + 1;
			end
			// lcd enable and dma activity against the tracked state
			if (lcd_on !== lcd_exp) begin
				$display("error at %0d ns: lcd_on %b, expected %b", $time, lcd_on, lcd_exp);
				status_errors = status_errors + 1;
			end
			if (dma_rd !== dma_exp) begin
				$display("error at %0d ns: dma_rd %b, expected %b", $time, dma_rd, dma_exp);
				status_errors = status_errors + 1;
			end
			// each irq pulse is high for one cycle so high cycles count pulses
			if (win_on) begin
				irq_total    = irq_cnt + ((irq === 1'b1) ? 1 : 0);
				vblank_total = vblank_cnt + ((vblank_irq === 1'b1) ? 1 : 0);
				if (win_close) begin
					if (irq_total != exp_irq) begin
						$display("error at %0d ns: %0d irq pulses in window, expected %0d",
							$time, irq_total, exp_irq);
						count_errors = count_errors + 1;
					end
					if (vblank_total != exp_vblank) begin
						$display("error at %0d ns: %0d vblank pulses in window, expected %0d",
							$time, vblank_total, exp_vblank);
						count_errors = count_errors + 1;
					end
					irq_cnt    = 0;
					vblank_cnt = 0;
				end else begin
					irq_cnt    = irq_total;
					vblank_cnt = vblank_total;
				end
			end
		end
	end

endmodule

// File: tests/ppu_tb.sv
// --------------------------------------------------
// lcd controller testbench
// runs the trace file against the dut, models the
// dma source memory and bounds the run time
// --------------------------------------------------

module ppu_tb;
	timeunit 1ns;
	timeprecision 100ps;

	logic        clk_reg;
	logic        reset;
	logic        cpu_sel_oam;
	logic        cpu_sel_reg;
	logic        cpu_wr;
	logic [7:0]  cpu_addr;
	logic [7:0]  cpu_di;
	logic [7:0]  dma_data;
	logic [7:0]  cpu_do;
	logic        lcd_on;
	logic [1:0]  mode;
	logic        irq;
	logic        vblank_irq;
	logic        dma_rd;
	logic [15:0] dma_addr;

	// expectations handed to the checker
	logic        read_chk;
	logic [7:0]  read_exp;
	logic        mode_chk;
	logic [1:0]  mode_exp;
	logic        lcd_exp;
	logic        dma_exp;
	logic        win_on;
	logic        win_close;
	int          exp_irq;
	int          exp_vblank;
	int          dma_left;
	int          read_errors;
	int          mode_errors;
	int          count_errors;
	int          status_errors;
	int          trace_errors;

	// parsed trace with one entry per operation
	byte         op_q[$];
	int          a_q[$];
	int          b_q[$];
	int          c_q[$];
	real         budget_ns;
	logic        budget_ready;

	// source memory returns the low address byte xor the page
	assign dma_data = dma_rd ? (dma_addr[7:0] ^ dma_addr[15:8]) : 8'h00;

	// dma reads stay high while copy cycles remain
	assign dma_exp = (dma_left != 0);

	ppu_ctrl ppu_ctrl_i (
		.clk_reg     (clk_reg),
		.reset       (reset),
		.cpu_sel_oam (cpu_sel_oam),
		.cpu_sel_reg (cpu_sel_reg),
		.cpu_wr      (cpu_wr),
		.cpu_addr    (cpu_addr),
		.cpu_di      (cpu_di),
		.dma_data    (dma_data),
		.cpu_do      (cpu_do),
		.lcd_on      (lcd_on),
		.mode        (mode),
		.irq         (irq),
		.vblank_irq  (vblank_irq),
		.dma_rd      (dma_rd),
		.dma_addr    (dma_addr)
	);

	ppu_checker ppu_checker_i (
		.clk_reg       (clk_reg),
		.reset         (reset),
		.cpu_addr      (cpu_addr),
		.cpu_do        (cpu_do),
		.mode          (mode),
		.irq           (irq),
		.vblank_irq    (vblank_irq),
		.lcd_on        (lcd_on),
		.dma_rd        (dma_rd),
		.read_chk      (read_chk),
		.read_exp      (read_exp),
		.mode_chk      (mode_chk),
		.mode_exp      (mode_exp),
		.lcd_exp       (lcd_exp),
		.dma_exp       (dma_exp),
		.win_on        (win_on),
		.win_close     (win_close),
		.exp_irq       (exp_irq),
		.exp_vblank    (exp_vblank),
		.read_errors   (read_errors),
		.mode_errors   (mode_errors),
		.count_errors  (count_errors),
		.status_errors (status_errors)
	);

	// 40 ns register clock
	initial begin
		clk_reg = 1'b0;
		forever #20 clk_reg = ~clk_reg;
	end

	// --------------------------------------------------
	// helpers

	// inputs change 2 ns after the rising edge
	task automatic next_cycle();
		@(posedge clk_reg);
		#2;
		if (dma_left > 0)
			dma_left = dma_left - 1;
	endtask

	task automatic drive_idle();
		cpu_sel_oam = 1'b0;
		cpu_sel_reg = 1'b0;
		cpu_wr      = 1'b0;
		cpu_addr    = 8'h00;
		cpu_di      = 8'h00;
		read_chk    = 1'b0;
		mode_chk    = 1'b0;
		win_on      = 1'b0;
		win_close   = 1'b0;
	endtask

	task automatic load_trace();
		int    fd;
		int    n;
		int    a;
		int    b;
		int    c;
		byte   op;
		string line;
		fd = $fopen("tests/ppu_trace.txt", "r");
		if (fd == 0) begin
			$display("could not open the trace file tests/ppu_trace.txt");
			trace_errors = trace_errors + 1;
			return;
		end
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			// blank lines and # comments carry no operation
			if (line.len() < 2 || line[0] == "#")
				continue;
			op = line[0];
			a  = 0;
			b  = 0;
			c  = 0;
			case (op)
				"W", "R":
					n = ($sscanf(line, "%c %h %h %h", op, a, b, c) == 4);
				"C":
					n = ($sscanf(line, "%c %d %d %d", op, a, b, c) == 4);
				"M":
					n = ($sscanf(line, "%c %d", op, a) == 2);
				default:
					n = 0;
			endcase
			if (n == 0) begin
				$display("the trace line '%s' could not be understood", line);
				trace_errors = trace_errors + 1;
			end else begin
				op_q.push_back(op);
				a_q.push_back(a);
				b_q.push_back(b);
				c_q.push_back(c);
			end
		end
		$fclose(fd);
	endtask

	// one trace operation where W, R and M take one cycle and C takes its count
	task automatic run_op(input byte op, input int a, input int b, input int c);
		int i;
		case (op)
			"W": begin
				cpu_sel_reg = (a == 0);
				cpu_sel_oam = (a != 0);
				cpu_wr      = 1'b1;
				cpu_addr    = b[7:0];
				cpu_di      = c[7:0];
				next_cycle();
				// lcdc bit 7 switches the lcd from the next cycle on
				if (a == 0 && b[7:0] == 8'h40)
					lcd_exp = c[7];
				// dma copies 160 bytes at four clocks each
				if (a == 0 && b[7:0] == 8'h46)
					dma_left = 160 * 4;
			end
			"R": begin
				cpu_sel_reg = (a == 0);
				cpu_sel_oam = (a != 0);
				cpu_addr    = b[7:0];
				read_chk    = 1'b1;
				read_exp    = c[7:0];
				next_cycle();
			end
			"M": begin
				mode_chk = 1'b1;
				mode_exp = a[1:0];
				next_cycle();
			end
			"C": begin
				win_on     = 1'b1;
				exp_irq    = b;
				exp_vblank = c;
				// checker compares on the last cycle of the window
				for (i = 0; i < a; i++) begin
					win_close = (i == a - 1);
					next_cycle();
				end
			end
			default: ;
		endcase
		drive_idle();
	endtask

	task automatic report_counts();
		$display("errors: %0d read, %0d mode, %0d irq count, %0d status, %0d trace",
			read_errors, mode_errors, count_errors, status_errors, trace_errors);
	endtask

	// --------------------------------------------------
	// main sequence
	initial begin
		longint total;
		drive_idle();
		reset        = 1'b1;
		read_exp     = 8'h00;
		mode_exp     = 2'd0;
		lcd_exp      = 1'b0;
		dma_left     = 0;
		exp_irq      = 0;
		exp_vblank   = 0;
		trace_errors = 0;
		budget_ready = 1'b0;
		load_trace();
		// one cycle per operation plus every wait and a tenth spare
		total = op_q.size();
		foreach (op_q[k])
			if (op_q[k] == "C")
				total = total + a_q[k];
		budget_ns    = real'(total) * 40.0 * 1.1;
		budget_ready = 1'b1;
		repeat (4) @(posedge clk_reg);
		#2;
		reset = 1'b0;
		foreach (op_q[k])
			run_op(op_q[k], a_q[k], b_q[k], c_q[k]);
		report_counts();
		if (read_errors + mode_errors + count_errors + status_errors + trace_errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

	// watchdog
	initial begin
		wait (budget_ready);
		#(budget_ns);
		$display("timeout: the trace did not complete within %0.0f ns", budget_ns);
		report_counts();
		$display("Testbench failed");
		$finish;
	end

endmodule

// File: all.f
common/ppu_pkg.sv
rtl/line_timer.sv
rtl/lcd_regs.sv
rtl/stat_irq.sv
oam_store/oam_store.sv
rtl/ppu_ctrl.sv
tests/ppu_checker.sv
tests/ppu_tb.sv

// File: Bender.yml
package:
  name: ppu_ctrl

sources:
  # shared package first, then the blocks, top level last
  - common/ppu_pkg.sv
  - rtl/line_timer.sv
  - rtl/lcd_regs.sv
  - rtl/stat_irq.sv
  - oam_store/oam_store.sv
  - rtl/ppu_ctrl.sv
  - target: test
    files:
      - tests/ppu_checker.sv
      - tests/ppu_tb.sv

// File: tests/ppu_trace.txt
# W sel addr data, R sel addr expected (hex, sel 0 = register, 1 = oam)
# C cycles irq_pulses vblank_pulses, M mode (decimal)
# reset values and readback, lcd still off
R 0 40 00
R 0 43 00
R 0 45 00
R 0 46 00
R 0 41 84
R 0 42 FF
W 0 40 11
R 0 40 11
W 0 43 5A
R 0 43 5A
W 0 45 37
R 0 45 37
W 0 43 00
W 0 45 00
# lcd on, h count restarts at 6
W 0 40 80
C 34 0 0
M 2
C 159 0 0
M 3
C 99 0 0
M 0
# scx 3 moves hblank to 264 from line 1
W 0 43 03
C 414 0 0
M 3
C 3 0 0
M 0
# oam mode irq, ten lines
W 0 41 20
C 4560 10 0
R 0 44 0B
W 0 41 00
# one frame with vblank irq enabled
W 0 41 10
C 70224 1 1
# one frame with hblank irq enabled
W 0 41 08
C 70224 144 1
# lyc write matching line 11
W 0 41 40
W 0 45 0B
C 10 1 0
R 0 41 C4
C 273 0 0
R 0 41 C3
# oam dma from page c1
W 0 46 C1
C 700 0 0
R 1 00 C1
R 1 01 C0
R 1 10 D1
R 1 4F 8E
R 1 9F 5E
# cpu write in mode 2 is dropped
C 115 0 0
M 2
W 1 10 55
R 1 10 D1
# lcd off, cpu write lands
W 0 40 00
M 0
R 0 44 00
W 1 10 55
R 1 10 55
